// ==== Makefile ====
# Verilator flow for the AXI4-lite physical memory.
VERILATOR ?= verilator
TOP       ?= tb_axil_pmem
SEED      ?= 72
FILELIST  ?= axil_pmem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== axil_pmem.f ====
hw/axil_pmem_pkg.sv
hw/pmem_ram.sv
hw/axil_pmem_slave.sv
hw/axil_read_arbiter.sv
hw/axil_pmem_top.sv
testbench/tb_axil_pmem.sv

// ==== hw/axil_pmem_pkg.sv ====
package axil_pmem_pkg;

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;   // one strobe per byte lane.

    localparam int mem_depth = 1024;              // words.
    localparam int mem_index_width = 10;

    typedef logic [addr_width-1:0] addr_t;        // byte address.
    typedef logic [data_width-1:0] data_t;
    typedef logic [strb_width-1:0] strb_t;
    typedef logic [mem_index_width-1:0] index_t;  // word index into the ram.
    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay = 2'd0;
    localparam resp_t resp_slverr = 2'd2;

    // read arbiter phases.
    typedef enum logic [1:0] {
        arb_idle,
        arb_addr,
        arb_data
    } arb_state_t;

endpackage

// ==== hw/axil_pmem_slave.sv ====
`timescale 1ns/10ps

module axil_pmem_slave (
    input  logic                   aclk,
    input  logic                   areset_n,

    input  logic                   awvalid,
    output logic                   awready,
    input  axil_pmem_pkg::addr_t   awaddr,

    input  logic                   wvalid,
    output logic                   wready,
    input  axil_pmem_pkg::data_t   wdata,
    input  axil_pmem_pkg::strb_t   wstrb,

    output logic                   bvalid,
    input  logic                   bready,
    output axil_pmem_pkg::resp_t   bresp,

    input  logic                   arvalid,
    output logic                   arready,
    input  axil_pmem_pkg::addr_t   araddr,

    output logic                   rvalid,
    input  logic                   rready,
    output axil_pmem_pkg::data_t   rdata,
    output axil_pmem_pkg::resp_t   rresp,

    output logic                   ram_we,
    output axil_pmem_pkg::index_t  ram_waddr,
    output axil_pmem_pkg::data_t   ram_wdata,
    output axil_pmem_pkg::strb_t   ram_wstrb,
    output logic                   ram_re,
    output axil_pmem_pkg::index_t  ram_raddr,
    input  axil_pmem_pkg::data_t   ram_rdata
);

    // no address bits set above the word index.
    function automatic logic in_range(axil_pmem_pkg::addr_t addr);
        return addr[axil_pmem_pkg::addr_width-1:axil_pmem_pkg::mem_index_width+2] == '0;
    endfunction

    function automatic axil_pmem_pkg::index_t word_index(axil_pmem_pkg::addr_t addr);
        return addr[axil_pmem_pkg::mem_index_width+1:2];
    endfunction

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic aw_done;                       // address captured.
    logic w_done;                        // data captured.
    axil_pmem_pkg::addr_t aw_buf;
    axil_pmem_pkg::data_t w_buf;
    axil_pmem_pkg::strb_t strb_buf;
    logic wr_fire;                       // pair is whole this cycle.
    axil_pmem_pkg::addr_t wr_addr;
    logic wr_ok;

    logic ar_hs;
    logic r_hs;
    logic rd_ok;

    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;
    assign b_hs = bvalid && bready;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            awready <= 1'b0;
            aw_done <= 1'b0;
        end else begin
            if (aw_hs) begin
                awready <= 1'b0;
            end else if (awvalid && !aw_done) begin
                awready <= 1'b1;
            end
            if (aw_hs) begin
                aw_done <= 1'b1;
            end else if (b_hs) begin
                aw_done <= 1'b0;           // freed by the response.
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            wready <= 1'b0;
            w_done <= 1'b0;
        end else begin
            if (w_hs) begin
                wready <= 1'b0;
            end else if (wvalid && !w_done) begin
                wready <= 1'b1;
            end
            if (w_hs) begin
                w_done <= 1'b1;
            end else if (b_hs) begin
                w_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            aw_buf <= awaddr;
        end
        if (w_hs) begin
            w_buf <= wdata;
            strb_buf <= wstrb;
        end
    end

    // live values win over the buffers in the completing cycle.
    assign wr_fire = (aw_hs && (w_done || w_hs)) || (w_hs && aw_done);
    assign wr_addr = aw_hs ? awaddr : aw_buf;
    assign wr_ok = in_range(wr_addr);

    assign ram_we = wr_fire && wr_ok;
    assign ram_waddr = word_index(wr_addr);
    assign ram_wdata = w_hs ? wdata : w_buf;
    assign ram_wstrb = w_hs ? wstrb : strb_buf;

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (b_hs) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? axil_pmem_pkg::resp_okay : axil_pmem_pkg::resp_slverr;
        end
    end

    assign ar_hs = arvalid && arready;
    assign r_hs = rvalid && rready;

    // rvalid doubles as the pending read flag.
    always_ff @(posedge aclk) begin
        if (areset_n) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                arready <= 1'b0;
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (r_hs) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            rd_ok <= in_range(araddr);
        end
    end

    assign ram_re = ar_hs;
    assign ram_raddr = word_index(araddr);
    assign rdata = rd_ok ? ram_rdata : '0;   // ram output holds until the next read.
    assign rresp = rd_ok ? axil_pmem_pkg::resp_okay : axil_pmem_pkg::resp_slverr;

    b_hold: assert property (@(posedge aclk) disable iff (areset_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

    r_hold: assert property (@(posedge aclk) disable iff (areset_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    // an out of range pair leaves memory alone and answers with an error.
    oor_write: assert property (@(posedge aclk) disable iff (areset_n)
        wr_fire && !wr_ok |-> !ram_we ##1 (bvalid && bresp == axil_pmem_pkg::resp_slverr));

endmodule

// ==== hw/axil_pmem_top.sv ====
`timescale 1ns/10ps

module axil_pmem_top (
    input  logic                   aclk,
    input  logic                   areset_n,

    input  logic                   if_arvalid,
    output logic                   if_arready,
    input  axil_pmem_pkg::addr_t   if_araddr,
    output logic                   if_rvalid,
    input  logic                   if_rready,
    output axil_pmem_pkg::data_t   if_rdata,
    output axil_pmem_pkg::resp_t   if_rresp,

    input  logic                   ls_arvalid,
    output logic                   ls_arready,
    input  axil_pmem_pkg::addr_t   ls_araddr,
    output logic                   ls_rvalid,
    input  logic                   ls_rready,
    output axil_pmem_pkg::data_t   ls_rdata,
    output axil_pmem_pkg::resp_t   ls_rresp,

    input  logic                   ls_awvalid,
    output logic                   ls_awready,
    input  axil_pmem_pkg::addr_t   ls_awaddr,
    input  logic                   ls_wvalid,
    output logic                   ls_wready,
    input  axil_pmem_pkg::data_t   ls_wdata,
    input  axil_pmem_pkg::strb_t   ls_wstrb,
    output logic                   ls_bvalid,
    input  logic                   ls_bready,
    output axil_pmem_pkg::resp_t   ls_bresp
);

    logic s_arvalid;                     // arbiter to slave.
    logic s_arready;
    axil_pmem_pkg::addr_t s_araddr;
    logic s_rvalid;
    logic s_rready;
    axil_pmem_pkg::data_t s_rdata;
    axil_pmem_pkg::resp_t s_rresp;

    logic ram_we;
    axil_pmem_pkg::index_t ram_waddr;
    axil_pmem_pkg::data_t ram_wdata;
    axil_pmem_pkg::strb_t ram_wstrb;
    logic ram_re;
    axil_pmem_pkg::index_t ram_raddr;
    axil_pmem_pkg::data_t ram_rdata;

    axil_read_arbiter i_read_arbiter (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .if_arvalid (if_arvalid),
        .if_arready (if_arready),
        .if_araddr  (if_araddr),
        .if_rvalid  (if_rvalid),
        .if_rready  (if_rready),
        .if_rdata   (if_rdata),
        .if_rresp   (if_rresp),
        .ls_arvalid (ls_arvalid),
        .ls_arready (ls_arready),
        .ls_araddr  (ls_araddr),
        .ls_rvalid  (ls_rvalid),
        .ls_rready  (ls_rready),
        .ls_rdata   (ls_rdata),
        .ls_rresp   (ls_rresp),
        .arvalid    (s_arvalid),
        .arready    (s_arready),
        .araddr     (s_araddr),
        .rvalid     (s_rvalid),
        .rready     (s_rready),
        .rdata      (s_rdata),
        .rresp      (s_rresp)
    );

    axil_pmem_slave i_pmem_slave (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .awvalid    (ls_awvalid),
        .awready    (ls_awready),
        .awaddr     (ls_awaddr),
        .wvalid     (ls_wvalid),
        .wready     (ls_wready),
        .wdata      (ls_wdata),
        .wstrb      (ls_wstrb),
        .bvalid     (ls_bvalid),
        .bready     (ls_bready),
        .bresp      (ls_bresp),
        .arvalid    (s_arvalid),
        .arready    (s_arready),
        .araddr     (s_araddr),
        .rvalid     (s_rvalid),
        .rready     (s_rready),
        .rdata      (s_rdata),
        .rresp      (s_rresp),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .ram_wstrb  (ram_wstrb),
        .ram_re     (ram_re),
        .ram_raddr  (ram_raddr),
        .ram_rdata  (ram_rdata)
    );

    pmem_ram i_pmem_ram (
        .aclk       (aclk),
        .we         (ram_we),
        .waddr      (ram_waddr),
        .wdata      (ram_wdata),
        .wstrb      (ram_wstrb),
        .re         (ram_re),
        .raddr      (ram_raddr),
        .rdata      (ram_rdata)
    );

endmodule

// ==== hw/axil_read_arbiter.sv ====
`timescale 1ns/10ps

module axil_read_arbiter (
    input  logic                   aclk,
    input  logic                   areset_n,

    input  logic                   if_arvalid,
    output logic                   if_arready,
    input  axil_pmem_pkg::addr_t   if_araddr,
    output logic                   if_rvalid,
    input  logic                   if_rready,
    output axil_pmem_pkg::data_t   if_rdata,
    output axil_pmem_pkg::resp_t   if_rresp,

    input  logic                   ls_arvalid,
    output logic                   ls_arready,
    input  axil_pmem_pkg::addr_t   ls_araddr,
    output logic                   ls_rvalid,
    input  logic                   ls_rready,
    output axil_pmem_pkg::data_t   ls_rdata,
    output axil_pmem_pkg::resp_t   ls_rresp,

    output logic                   arvalid,
    input  logic                   arready,
    output axil_pmem_pkg::addr_t   araddr,
    input  logic                   rvalid,
    output logic                   rready,
    input  axil_pmem_pkg::data_t   rdata,
    input  axil_pmem_pkg::resp_t   rresp
);

    axil_pmem_pkg::arb_state_t state;
    logic [1:0] grant;                   // bit 0 fetch, bit 1 load/store.
    logic prio;                          // set when load/store is preferred.
    logic pick_ls;
    logic ar_phase;
    logic r_phase;

    assign pick_ls = ls_arvalid && (!if_arvalid || prio);

    always_ff @(posedge aclk) begin
        if (areset_n) begin
            state <= axil_pmem_pkg::arb_idle;
            grant <= 2'b00;
            prio <= 1'b0;                // fetch first.
        end else begin
            case (state)
                axil_pmem_pkg::arb_idle: begin
                    if (if_arvalid || ls_arvalid) begin
                        grant <= pick_ls ? 2'b10 : 2'b01;
                        state <= axil_pmem_pkg::arb_addr;
                    end
                end
                axil_pmem_pkg::arb_addr: begin
                    if (arvalid && arready) begin
                        state <= axil_pmem_pkg::arb_data;
                    end
                end
                axil_pmem_pkg::arb_data: begin
                    if (rvalid && rready) begin
                        prio <= grant[0];    // hand priority to the other port.
                        state <= axil_pmem_pkg::arb_idle;
                    end
                end
                default: begin
                    state <= axil_pmem_pkg::arb_idle;
                end
            endcase
        end
    end

    assign ar_phase = state == axil_pmem_pkg::arb_addr;
    assign r_phase = state == axil_pmem_pkg::arb_data;

    assign arvalid = ar_phase && (grant[1] ? ls_arvalid : if_arvalid);
    assign araddr = grant[1] ? ls_araddr : if_araddr;
    assign if_arready = ar_phase && grant[0] && arready;
    assign ls_arready = ar_phase && grant[1] && arready;

    assign rready = r_phase && (grant[1] ? ls_rready : if_rready);
    assign if_rvalid = r_phase && grant[0] && rvalid;
    assign ls_rvalid = r_phase && grant[1] && rvalid;
    assign if_rdata = rdata;             // qualified by the gated valid.
    assign if_rresp = rresp;
    assign ls_rdata = rdata;
    assign ls_rresp = rresp;

    grant_check: assert property (@(posedge aclk) disable iff (areset_n)
        $onehot0(grant) && (!$stable(grant) -> $past(state) == axil_pmem_pkg::arb_idle));

endmodule

// ==== hw/pmem_ram.sv ====
`timescale 1ns/10ps

module pmem_ram (
    input  logic                   aclk,
    input  logic                   we,
    input  axil_pmem_pkg::index_t  waddr,
    input  axil_pmem_pkg::data_t   wdata,
    input  axil_pmem_pkg::strb_t   wstrb,
    input  logic                   re,
    input  axil_pmem_pkg::index_t  raddr,
    output axil_pmem_pkg::data_t   rdata
);

    axil_pmem_pkg::data_t mem [axil_pmem_pkg::mem_depth];

    // byte lane write.
    always_ff @(posedge aclk) begin
        if (we) begin
            for (int i = 0; i < axil_pmem_pkg::strb_width; i++) begin
                if (wstrb[i]) begin
                    mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, a colliding write is seen one cycle later.
    always_ff @(posedge aclk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== testbench/tb_axil_pmem.sv ====
`timescale 1ns/10ps

module tb_axil_pmem #(
    parameter int seed = 72,
    parameter int wait_limit = 200
);

    logic aclk;
    logic areset_n;
    logic if_arvalid;
    logic if_arready;
    axil_pmem_pkg::addr_t if_araddr;
    logic if_rvalid;
    logic if_rready;
    axil_pmem_pkg::data_t if_rdata;
    axil_pmem_pkg::resp_t if_rresp;
    logic ls_arvalid;
    logic ls_arready;
    axil_pmem_pkg::addr_t ls_araddr;
    logic ls_rvalid;
    logic ls_rready;
    axil_pmem_pkg::data_t ls_rdata;
    axil_pmem_pkg::resp_t ls_rresp;
    logic ls_awvalid;
    logic ls_awready;
    axil_pmem_pkg::addr_t ls_awaddr;
    logic ls_wvalid;
    logic ls_wready;
    axil_pmem_pkg::data_t ls_wdata;
    axil_pmem_pkg::strb_t ls_wstrb;
    logic ls_bvalid;
    logic ls_bready;
    axil_pmem_pkg::resp_t ls_bresp;

    logic [1:0] arready_v;                    // indexed by port, 1 is load/store.
    logic [1:0] rvalid_v;
    axil_pmem_pkg::data_t ref_mem [axil_pmem_pkg::index_t];
    axil_pmem_pkg::index_t keys [$];
    int done_cnt [2];                         // completed reads per port.
    int errors;
    int checks;
    string test_name;

    assign arready_v = {ls_arready, if_arready};
    assign rvalid_v = {ls_rvalid, if_rvalid};

    axil_pmem_top i_axil_pmem_top (.*);

    always #50 aclk = ~aclk;

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        errors++;
        $display("%s: timed out waiting for %s", test_name, what);
        finish_run();
    endtask

    task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    function automatic logic addr_ok(axil_pmem_pkg::addr_t addr);
        return addr[31:12] == 20'd0;          // bits above the word index.
    endfunction

    function automatic axil_pmem_pkg::data_t merge_bytes(axil_pmem_pkg::data_t old_word,
            axil_pmem_pkg::data_t new_word, axil_pmem_pkg::strb_t strb);
        axil_pmem_pkg::data_t word;
        word = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic send_aw(axil_pmem_pkg::addr_t addr);
        int t;
        ls_awvalid <= 1'b1;
        ls_awaddr <= addr;
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (!ls_awready && t < wait_limit);
        if (!ls_awready) give_up("awready");
        @(posedge aclk);                      // transfer edge.
        ls_awvalid <= 1'b0;
    endtask

    task automatic send_w(axil_pmem_pkg::data_t data, axil_pmem_pkg::strb_t strb);
        int t;
        ls_wvalid <= 1'b1;
        ls_wdata <= data;
        ls_wstrb <= strb;
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (!ls_wready && t < wait_limit);
        if (!ls_wready) give_up("wready");
        @(posedge aclk);
        ls_wvalid <= 1'b0;
    endtask

    task automatic take_b(output axil_pmem_pkg::resp_t resp);
        int t;
        int span;
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (!ls_bvalid && t < wait_limit);
        if (!ls_bvalid) give_up("bvalid");
        resp = ls_bresp;
        span = $urandom_range(0, 4);
        repeat (span) begin
            @(negedge aclk);
            check_true(ls_bvalid && ls_bresp === resp, "b response changed while bready was low");
        end
        @(posedge aclk);
        ls_bready <= 1'b1;
        @(negedge aclk);
        check_true(ls_bvalid, "bvalid dropped before the handshake");
        @(posedge aclk);
        ls_bready <= 1'b0;
        @(negedge aclk);
        check_true(!ls_bvalid, "a second b response followed the handshake");
    endtask

    // order 0 sends AW first, 1 sends W first, anything else sends both together.
    task automatic write_word(axil_pmem_pkg::addr_t addr, axil_pmem_pkg::data_t data,
            axil_pmem_pkg::strb_t strb, int order);
        axil_pmem_pkg::resp_t resp;
        axil_pmem_pkg::index_t idx;
        idx = addr[11:2];
        @(posedge aclk);
        case (order)
            0: begin
                send_aw(addr);
                send_w(data, strb);
            end
            1: begin
                send_w(data, strb);
                send_aw(addr);
            end
            default: begin
                fork
                    send_aw(addr);
                    send_w(data, strb);
                join
            end
        endcase
        take_b(resp);
        check_value("bresp", 32'(addr_ok(addr) ? axil_pmem_pkg::resp_okay
            : axil_pmem_pkg::resp_slverr), 32'(resp));
        if (addr_ok(addr)) begin
            ref_mem[idx] = merge_bytes(ref_mem.exists(idx) ? ref_mem[idx] : '0, data, strb);
        end
    endtask

    // starts and ends on a rising edge, so reads can follow each other back to back.
    task automatic read_port(bit ls, axil_pmem_pkg::addr_t addr,
            output axil_pmem_pkg::data_t data, output axil_pmem_pkg::resp_t resp);
        int t;
        int span;
        int other_start;
        other_start = done_cnt[!ls];
        if (ls) begin
            ls_arvalid <= 1'b1;
            ls_araddr <= addr;
        end else begin
            if_arvalid <= 1'b1;
            if_araddr <= addr;
        end
        @(negedge aclk);
        check_true(!rvalid_v[ls], "an r response was pending before the request");
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (!arready_v[ls] && t < wait_limit);
        if (!arready_v[ls]) give_up("arready");
        @(posedge aclk);
        if (ls) begin
            ls_arvalid <= 1'b0;
        end else begin
            if_arvalid <= 1'b0;
        end
        t = 0;
        do begin
            @(negedge aclk);
            t++;
        end while (!rvalid_v[ls] && t < wait_limit);
        if (!rvalid_v[ls]) give_up("rvalid");
        data = ls ? ls_rdata : if_rdata;
        resp = ls ? ls_rresp : if_rresp;
        span = $urandom_range(0, 4);
        repeat (span) begin
            @(negedge aclk);
            check_true(rvalid_v[ls] && (ls ? ls_rdata : if_rdata) === data
                && (ls ? ls_rresp : if_rresp) === resp, "r response changed while rready was low");
        end
        @(posedge aclk);
        if (ls) begin
            ls_rready <= 1'b1;
        end else begin
            if_rready <= 1'b1;
        end
        @(negedge aclk);
        check_true(rvalid_v[ls], "rvalid dropped before the handshake");
        @(posedge aclk);                      // transfer edge.
        if (ls) begin
            ls_rready <= 1'b0;
        end else begin
            if_rready <= 1'b0;
        end
        done_cnt[ls]++;
        check_true(done_cnt[!ls] - other_start <= 2, "a read port waited too long for a grant");
    endtask

    task automatic read_rounds(bit ls, int rounds);
        axil_pmem_pkg::index_t idx;
        axil_pmem_pkg::data_t data;
        axil_pmem_pkg::resp_t resp;
        for (int i = 0; i < rounds; i++) begin
            idx = keys[$urandom_range(0, keys.size() - 1)];
            read_port(ls, {20'd0, idx, 2'b00}, data, resp);
            check_value("rdata", ref_mem[idx], data);
            check_value("rresp", 32'(axil_pmem_pkg::resp_okay), 32'(resp));
        end
    endtask

    initial begin
        axil_pmem_pkg::addr_t addr;
        axil_pmem_pkg::addr_t far_addr;
        axil_pmem_pkg::data_t data;
        axil_pmem_pkg::resp_t resp;
        logic [31:0] r;
        void'($urandom(seed));
        errors = 0;
        checks = 0;
        done_cnt[0] = 0;
        done_cnt[1] = 0;
        aclk = 1'b0;
        areset_n = 1'b1;                      // reset is active high.
        if_arvalid = 1'b0;
        if_araddr = '0;
        if_rready = 1'b0;
        ls_arvalid = 1'b0;
        ls_araddr = '0;
        ls_rready = 1'b0;
        ls_awvalid = 1'b0;
        ls_awaddr = '0;
        ls_wvalid = 1'b0;
        ls_wdata = '0;
        ls_wstrb = '0;
        ls_bready = 1'b0;

        test_name = "reset";
        repeat (4) @(posedge aclk);
        areset_n <= 1'b0;
        repeat (3) begin
            @(negedge aclk);
            check_true(!(if_arready || if_rvalid || ls_arready || ls_rvalid || ls_awready
                || ls_wready || ls_bvalid), "a valid or ready output is high after reset");
        end

        test_name = "write_read";
        repeat (8) begin
            r = $urandom();
            addr = {20'd0, r[9:0], 2'b00};
            data = $urandom();
            write_word(addr, data, 4'hf, $urandom_range(0, 2));
            @(posedge aclk);
            read_port(1'b1, addr, data, resp);
            check_value("rdata", ref_mem[addr[11:2]], data);
            check_value("rresp", 32'(axil_pmem_pkg::resp_okay), 32'(resp));
        end

        test_name = "byte_strobe";
        for (int i = 0; i < 12; i++) begin
            r = $urandom();
            addr = {20'd0, r[9:0], 2'b00};
            write_word(addr, $urandom(), 4'hf, (i + 1) % 3);
            r = $urandom();
            write_word(addr, $urandom(), r[3:0], i % 3);   // partial lanes.
            @(posedge aclk);
            read_port(1'b1, addr, data, resp);
            check_value("rdata", ref_mem[addr[11:2]], data);
        end

        test_name = "out_of_range";
        repeat (6) begin
            r = $urandom();
            addr = {20'd0, r[9:0], 2'b00};
            write_word(addr, $urandom(), 4'hf, 2);
            r = $urandom();
            far_addr = {r[19:1], 1'b1, addr[11:0]};       // same index, upper bits set.
            write_word(far_addr, $urandom(), 4'hf, $urandom_range(0, 2));
            @(posedge aclk);
            read_port(1'b0, addr, data, resp);
            check_value("aliased rdata", ref_mem[addr[11:2]], data);
            read_port(1'b1, far_addr, data, resp);
            check_value("rdata", 32'd0, data);
            check_value("rresp", 32'(axil_pmem_pkg::resp_slverr), 32'(resp));
        end

        test_name = "arbitration";
        foreach (ref_mem[k]) begin
            keys.push_back(k);
        end
        fork
            read_rounds(1'b0, 24);
            read_rounds(1'b1, 24);
        join

        finish_run();
    end

endmodule
